/* hw/mc51_pkg.sv */
`default_nettype none

package mc51_pkg;

	// Timing phase of the instruction sequencer
	typedef enum logic [3:0] {
		S1_0 = 4'h0,
		S1_1 = 4'h1,
		S2_0 = 4'h2,
		S2_1 = 4'h3,
		S4_0 = 4'h4,
		S4_1 = 4'h5,
		S5_0 = 4'h6,
		S5_1 = 4'h7,
		S6_0 = 4'h8,
		S6_1 = 4'h9,
		HALT = 4'hF
	} mc51_phase_e;

	// Operand fetch source in S2
	typedef enum logic [2:0] {
		DISCARD    = 3'd0,
		IND_EXROM  = 3'd1,
		IND_EXRAM  = 3'd2,
		IND_IRAM   = 3'd3,
		DIR_IRAM   = 3'd4
	} mc51_fetch_mode_e;

	// Write-back target in S5
	typedef enum logic [2:0] {
		WR_DISCARD  = 3'd0,
		WR_IND_IRAM = 3'd1,
		WR_DIR_IRAM = 3'd2,
		WR_EXRAM    = 3'd3
	} mc51_write_mode_e;

	// Register transfer in S4
	typedef enum logic [2:0] {
		TAR_NONE = 3'd0,
		TAR_ACC  = 3'd1,
		TAR_B    = 3'd2,
		TAR_SP   = 3'd3,
		TAR_DPH  = 3'd4,
		TAR_DPL  = 3'd5
	} mc51_reg_tar_e;

	typedef enum logic [1:0] {
		SRC_ZERO   = 2'd0,
		SRC_S2_BUF = 2'd1,
		SRC_ALU_O1 = 2'd2,
		SRC_ALU_O2 = 2'd3
	} mc51_reg_src_e;

	// PC reload applied in S6_0
	typedef enum logic [1:0] {
		PC_NUL = 2'd0,
		PC_11B = 2'd1,
		PC_ROF = 2'd2,
		PC_IND = 2'd3
	} mc51_pc_reload_e;

	// Micro-control word, stable over one instruction
	typedef struct packed {
		mc51_fetch_mode_e fetch_mode;
		mc51_write_mode_e write_mode;
		mc51_reg_tar_e    reg_tar;
		mc51_reg_src_e    reg_src;
		mc51_pc_reload_e  pc_reload;
		logic             s2_update_pc;
	} mc51_uop_t;

	// External bus strobes, all active low
	typedef struct packed {
		logic rd_n;
		logic we_n;
		logic psen_n;
	} mc51_bus_t;

	// Core SFR addresses
	localparam logic [7:0] SFR_ACC = 8'hE0;
	localparam logic [7:0] SFR_B   = 8'hF0;
	localparam logic [7:0] SFR_SP  = 8'h81;
	localparam logic [7:0] SFR_DPL = 8'h82;
	localparam logic [7:0] SFR_DPH = 8'h83;
	localparam logic [7:0] SFR_PSW = 8'hD0;

	localparam logic [7:0] IRAM_UPPER_BASE = 8'h80;
	localparam int         IRAM_SIZE       = 128;

	localparam logic [15:0] PC_RESET  = 16'h0000;
	localparam logic [7:0]  SP_RESET  = 8'h07;
	localparam logic [7:0]  PSW_RESET = 8'h00;

endpackage

`default_nettype wire

/* hw/mc51_phase_seq.sv */
`timescale 1ns/10ps
`default_nettype none

module mc51_phase_seq import mc51_pkg::*; (
	input  wire              clk,
	input  wire              reset_n,
	input  mc51_uop_t        i_uop,
	input  wire              i_s2_is_upper,
	input  wire              i_s2_is_core_sfr,
	input  wire              i_s5_is_upper,
	input  wire              i_s5_is_core_sfr,
	input  wire  [7:0]       i_mem_rdata,
	input  wire  [7:0]       i_s2_rdata,
	input  wire              i_data_rdy,
	input  wire              i_alu_ready,
	output mc51_phase_e      o_phase,
	output mc51_bus_t        o_bus,
	output logic [7:0]       o_instr_buf,
	output logic [7:0]       o_s2_buf,
	output logic             o_s1_done,
	output logic             o_s2_done,
	output logic             o_s6_done,
	output logic             o_reg_load,
	output logic             o_iram_wr,
	output logic             o_sfr_wr,
	output logic             o_instr_done
);

	mc51_phase_e phase_q;
	mc51_phase_e phase_d;
	logic        s2_ld;
	logic [7:0]  s2_data;

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			phase_q <= S1_0;
		end else begin
			phase_q <= phase_d;
		end
	end

	// Opcode latched on the S1 ready edge
	always_ff @(posedge clk) begin
		if (o_s1_done) begin
			o_instr_buf <= i_mem_rdata;
		end
		if (s2_ld) begin
			o_s2_buf <= s2_data;
		end
	end

	always_comb begin
		phase_d      = phase_q;
		o_bus.rd_n   = 1'b1;
		o_bus.we_n   = 1'b1;
		o_bus.psen_n = 1'b1;
		o_s1_done    = 1'b0;
		o_s2_done    = 1'b0;
		o_s6_done    = 1'b0;
		o_reg_load   = 1'b0;
		o_iram_wr    = 1'b0;
		o_sfr_wr     = 1'b0;
		o_instr_done = 1'b0;
		s2_ld        = 1'b0;
		s2_data      = i_mem_rdata;
		case (phase_q)
			// Opcode read from program memory
			S1_0: begin
				o_bus.rd_n   = 1'b0;
				o_bus.psen_n = 1'b0;
				phase_d      = S1_1;
			end
			S1_1: begin
				o_bus.rd_n   = 1'b0;
				o_bus.psen_n = 1'b0;
				if (i_data_rdy) begin
					o_s1_done = 1'b1;
					case (i_uop.fetch_mode)
						DISCARD:   phase_d = S4_0;
						IND_EXROM,
						IND_EXRAM,
						IND_IRAM,
						DIR_IRAM:  phase_d = S2_0;
						default:   phase_d = HALT;
					endcase
				end
			end
			S2_0: begin
				case (i_uop.fetch_mode)
					IND_EXROM: begin
						o_bus.rd_n   = 1'b0;
						o_bus.psen_n = 1'b0;
						phase_d      = S2_1;
					end
					IND_EXRAM: begin
						o_bus.rd_n = 1'b0;
						phase_d    = S2_1;
					end
					IND_IRAM,
					DIR_IRAM: begin
						// Indirect access has no SFR space above 0x7F
						if (i_s2_is_upper && i_uop.fetch_mode == IND_IRAM) begin
							phase_d = HALT;
						end else begin
							s2_ld   = 1'b1;
							s2_data = (!i_s2_is_upper || i_s2_is_core_sfr) ? i_s2_rdata : 8'h00;
							phase_d = S4_0;
						end
					end
					default: phase_d = HALT;
				endcase
			end
			// External operand, strobes held until ready
			S2_1: begin
				o_bus.rd_n   = 1'b0;
				o_bus.psen_n = (i_uop.fetch_mode != IND_EXROM);
				if (i_data_rdy) begin
					o_s2_done = 1'b1;
					s2_ld     = 1'b1;
					phase_d   = S4_0;
				end
			end
			S4_0: begin
				if (i_alu_ready) begin
					phase_d = S4_1;
				end
			end
			S4_1: begin
				o_reg_load = 1'b1;
				phase_d    = S5_0;
			end
			S5_0: begin
				case (i_uop.write_mode)
					WR_DISCARD: phase_d = S6_0;
					WR_IND_IRAM,
					WR_DIR_IRAM: begin
						// Upper indirect writes are dropped, non-core SFRs too
						if (!i_s5_is_upper) begin
							o_iram_wr = 1'b1;
						end else if (i_uop.write_mode == WR_DIR_IRAM) begin
							o_sfr_wr = i_s5_is_core_sfr;
						end
						phase_d = S6_0;
					end
					WR_EXRAM: begin
						o_bus.we_n = 1'b0;
						phase_d    = S5_1;
					end
					default: phase_d = HALT;
				endcase
			end
			S5_1: begin
				o_bus.we_n = 1'b0;
				if (i_data_rdy) begin
					phase_d = S6_0;
				end
			end
			// Jump reload point
			S6_0: begin
				o_s6_done = 1'b1;
				phase_d   = S6_1;
			end
			S6_1: begin
				o_instr_done = 1'b1;
				phase_d      = S1_0;
			end
			HALT:    phase_d = HALT;
			default: phase_d = HALT;
		endcase
		// Bus stays idle while reset is held
		if (!reset_n) begin
			o_bus = '1;
		end
	end

	assign o_phase = phase_q;

	// Read and write strobes are exclusive
	a_rd_we_excl: assert property (@(posedge clk) disable iff (!reset_n)
		!(!o_bus.rd_n && !o_bus.we_n));

	// Only reset leaves HALT
	a_halt_sticky: assert property (@(posedge clk) disable iff (!reset_n)
		phase_q == HALT |=> phase_q == HALT);

endmodule

`default_nettype wire

/* hw/mc51_core_regs.sv */
`timescale 1ns/10ps
`default_nettype none

module mc51_core_regs import mc51_pkg::*; (
	input  wire              clk,
	input  wire              reset_n,
	input  wire              i_reg_load,
	input  mc51_reg_tar_e    i_reg_tar,
	input  mc51_reg_src_e    i_reg_src,
	input  wire  [7:0]       i_s2_buf,
	input  wire  [7:0]       i_alu_o1,
	input  wire  [7:0]       i_alu_o2,
	input  wire  [7:0]       i_alu_psw,
	input  wire              i_sfr_wr,
	input  wire  [7:0]       i_s5_addr,
	input  wire  [7:0]       i_wdata,
	output logic [7:0]       o_acc,
	output logic [7:0]       o_b,
	output logic [7:0]       o_sp,
	output logic [7:0]       o_dph,
	output logic [7:0]       o_dpl,
	output logic [7:0]       o_psw
);

	logic [7:0] src_data;

	// Transfer source select
	always_comb begin
		case (i_reg_src)
			SRC_S2_BUF: src_data = i_s2_buf;
			SRC_ALU_O1: src_data = i_alu_o1;
			SRC_ALU_O2: src_data = i_alu_o2;
			default:    src_data = 8'h00;
		endcase
	end

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_acc <= 8'h00;
			o_b   <= 8'h00;
			o_sp  <= SP_RESET;
			o_dph <= 8'h00;
			o_dpl <= 8'h00;
			o_psw <= PSW_RESET;
		end else if (i_reg_load) begin
			// PSW always follows the ALU flags in S4_1
			o_psw <= i_alu_psw;
			case (i_reg_tar)
				TAR_ACC: o_acc <= src_data;
				TAR_B:   o_b   <= src_data;
				TAR_SP:  o_sp  <= src_data;
				TAR_DPH: o_dph <= src_data;
				TAR_DPL: o_dpl <= src_data;
				default: ;
			endcase
		end else if (i_sfr_wr) begin
			// Direct SFR write-back, PSW not writable here
			case (i_s5_addr)
				SFR_ACC: o_acc <= i_wdata;
				SFR_B:   o_b   <= i_wdata;
				SFR_SP:  o_sp  <= i_wdata;
				SFR_DPL: o_dpl <= i_wdata;
				SFR_DPH: o_dph <= i_wdata;
				default: ;
			endcase
		end
	end

	// S4 load and S5 SFR write never share a cycle
	a_load_wr_excl: assert property (@(posedge clk) disable iff (!reset_n)
		!(i_reg_load && i_sfr_wr));

endmodule

`default_nettype wire

/* hw/mc51_pc_unit.sv */
`timescale 1ns/10ps
`default_nettype none

module mc51_pc_unit import mc51_pkg::*; (
	input  wire              clk,
	input  wire              reset_n,
	input  wire              i_s1_done,
	input  wire              i_s2_done,
	input  wire              i_s2_update_pc,
	input  wire              i_s6_done,
	input  wire              i_jp_active,
	input  mc51_pc_reload_e  i_pc_reload,
	input  wire  [7:0]       i_instr_buf,
	input  wire  [7:0]       i_s2_buf,
	input  wire  [7:0]       i_acc,
	input  wire  [7:0]       i_dph,
	input  wire  [7:0]       i_dpl,
	output logic [15:0]      o_pc
);

	always_ff @(posedge clk or negedge reset_n) begin
		if (!reset_n) begin
			o_pc <= PC_RESET;
		end else if (i_s1_done || (i_s2_done && i_s2_update_pc)) begin
			o_pc <= o_pc + 16'd1;
		end else if (i_s6_done && i_jp_active) begin
			case (i_pc_reload)
				// Absolute jump inside the current 2 KB page
				PC_11B: o_pc <= {o_pc[15:11], i_instr_buf[7:5], i_s2_buf};
				// Relative jump, signed offset
				PC_ROF: o_pc <= o_pc + {{8{i_s2_buf[7]}}, i_s2_buf};
				// @A+DPTR
				PC_IND: o_pc <= {i_dph, i_dpl} + {8'h00, i_acc};
				default: ;
			endcase
		end
	end

endmodule

`default_nettype wire

/* hw/mc51_data_space.sv */
`timescale 1ns/10ps
`default_nettype none

module mc51_data_space import mc51_pkg::*; (
	input  wire        clk,
	input  wire  [7:0] i_s2_addr,
	input  wire  [7:0] i_s5_addr,
	input  wire        i_iram_wr,
	input  wire  [7:0] i_wdata,
	input  wire  [7:0] i_acc,
	input  wire  [7:0] i_b,
	input  wire  [7:0] i_sp,
	input  wire  [7:0] i_dph,
	input  wire  [7:0] i_dpl,
	input  wire  [7:0] i_psw,
	output logic [7:0] o_s2_rdata,
	output logic       o_s2_is_upper,
	output logic       o_s2_is_core_sfr,
	output logic       o_s5_is_upper,
	output logic       o_s5_is_core_sfr
);

	// Lower 128 bytes of internal RAM
	logic [7:0] iram [0:IRAM_SIZE-1];

	function automatic logic is_core_sfr(input logic [7:0] addr);
		return (addr == SFR_ACC) || (addr == SFR_B) || (addr == SFR_SP) ||
			(addr == SFR_DPL) || (addr == SFR_DPH) || (addr == SFR_PSW);
	endfunction

	assign o_s2_is_upper    = (i_s2_addr >= IRAM_UPPER_BASE);
	assign o_s5_is_upper    = (i_s5_addr >= IRAM_UPPER_BASE);
	assign o_s2_is_core_sfr = is_core_sfr(i_s2_addr);
	assign o_s5_is_core_sfr = is_core_sfr(i_s5_addr);

	always_ff @(posedge clk) begin
		if (i_iram_wr) begin
			iram[i_s5_addr[$clog2(IRAM_SIZE)-1:0]] <= i_wdata;
		end
	end

	// S2 read, RAM below 0x80 and SFRs above
	always_comb begin
		if (!o_s2_is_upper) begin
			o_s2_rdata = iram[i_s2_addr[$clog2(IRAM_SIZE)-1:0]];
		end else begin
			case (i_s2_addr)
				SFR_ACC: o_s2_rdata = i_acc;
				SFR_B:   o_s2_rdata = i_b;
				SFR_SP:  o_s2_rdata = i_sp;
				SFR_DPL: o_s2_rdata = i_dpl;
				SFR_DPH: o_s2_rdata = i_dph;
				SFR_PSW: o_s2_rdata = i_psw;
				default: o_s2_rdata = 8'h00;
			endcase
		end
	end

	// Sequencer must never request a RAM write above 0x7F
	a_no_upper_wr: assert property (@(posedge clk) i_iram_wr |-> !o_s5_is_upper);

endmodule

`default_nettype wire

/* hw/mc51_cu.sv */
`timescale 1ns/10ps
`default_nettype none

module mc51_cu import mc51_pkg::*; (
	input  wire              clk,
	input  wire              reset_n,
	input  mc51_uop_t        i_uop,
	input  wire  [15:0]      i_s2_addr,
	input  wire  [15:0]      i_s5_addr,
	input  wire  [7:0]       i_mem_rdata,
	input  wire  [7:0]       i_mem_wdata,
	input  wire              i_data_rdy,
	input  wire  [7:0]       i_alu_o1,
	input  wire  [7:0]       i_alu_o2,
	input  wire  [7:0]       i_alu_psw,
	input  wire              i_alu_ready,
	input  wire              i_jp_active,
	output mc51_bus_t        o_bus,
	output mc51_phase_e      o_phase,
	output wire  [15:0]      o_pc,
	output wire  [7:0]       o_acc,
	output wire  [7:0]       o_b,
	output wire  [7:0]       o_sp,
	output wire  [7:0]       o_dph,
	output wire  [7:0]       o_dpl,
	output wire  [7:0]       o_psw,
	output wire  [7:0]       o_instr_buf,
	output wire  [7:0]       o_s2_buf,
	output wire              o_instr_done
);

	// Sequencer pulses
	wire       s1_done;
	wire       s2_done;
	wire       s6_done;
	wire       reg_load;
	wire       iram_wr;
	wire       sfr_wr;
	// Data space classification
	wire [7:0] s2_rdata;
	wire       s2_is_upper;
	wire       s2_is_core_sfr;
	wire       s5_is_upper;
	wire       s5_is_core_sfr;

	mc51_phase_seq u_seq (
		.clk(clk), .reset_n(reset_n), .i_uop(i_uop),
		.i_s2_is_upper(s2_is_upper), .i_s2_is_core_sfr(s2_is_core_sfr),
		.i_s5_is_upper(s5_is_upper), .i_s5_is_core_sfr(s5_is_core_sfr),
		.i_mem_rdata(i_mem_rdata), .i_s2_rdata(s2_rdata),
		.i_data_rdy(i_data_rdy), .i_alu_ready(i_alu_ready),
		.o_phase(o_phase), .o_bus(o_bus),
		.o_instr_buf(o_instr_buf), .o_s2_buf(o_s2_buf),
		.o_s1_done(s1_done), .o_s2_done(s2_done), .o_s6_done(s6_done),
		.o_reg_load(reg_load), .o_iram_wr(iram_wr), .o_sfr_wr(sfr_wr),
		.o_instr_done(o_instr_done)
	);

	// Only the low address byte reaches internal RAM and SFRs
	mc51_data_space u_dspace (
		.clk(clk), .i_s2_addr(i_s2_addr[7:0]), .i_s5_addr(i_s5_addr[7:0]),
		.i_iram_wr(iram_wr), .i_wdata(i_mem_wdata),
		.i_acc(o_acc), .i_b(o_b), .i_sp(o_sp), .i_dph(o_dph), .i_dpl(o_dpl), .i_psw(o_psw),
		.o_s2_rdata(s2_rdata), .o_s2_is_upper(s2_is_upper),
		.o_s2_is_core_sfr(s2_is_core_sfr), .o_s5_is_upper(s5_is_upper),
		.o_s5_is_core_sfr(s5_is_core_sfr)
	);

	mc51_core_regs u_regs (
		.clk(clk), .reset_n(reset_n), .i_reg_load(reg_load),
		.i_reg_tar(i_uop.reg_tar), .i_reg_src(i_uop.reg_src), .i_s2_buf(o_s2_buf),
		.i_alu_o1(i_alu_o1), .i_alu_o2(i_alu_o2), .i_alu_psw(i_alu_psw),
		.i_sfr_wr(sfr_wr), .i_s5_addr(i_s5_addr[7:0]), .i_wdata(i_mem_wdata),
		.o_acc(o_acc), .o_b(o_b), .o_sp(o_sp), .o_dph(o_dph), .o_dpl(o_dpl), .o_psw(o_psw)
	);

	mc51_pc_unit u_pc (
		.clk(clk), .reset_n(reset_n), .i_s1_done(s1_done), .i_s2_done(s2_done),
		.i_s2_update_pc(i_uop.s2_update_pc), .i_s6_done(s6_done),
		.i_jp_active(i_jp_active), .i_pc_reload(i_uop.pc_reload),
		.i_instr_buf(o_instr_buf), .i_s2_buf(o_s2_buf),
		.i_acc(o_acc), .i_dph(o_dph), .i_dpl(o_dpl), .o_pc(o_pc)
	);

endmodule

`default_nettype wire

/* test/tb_mc51_cu.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_mc51_cu import mc51_pkg::*; ();

	logic        clk;
	logic        reset_n;
	mc51_uop_t   i_uop;
	logic [15:0] i_s2_addr;
	logic [15:0] i_s5_addr;
	logic [7:0]  i_mem_rdata;
	logic [7:0]  i_mem_wdata;
	logic        i_data_rdy;
	logic [7:0]  i_alu_o1;
	logic [7:0]  i_alu_o2;
	logic [7:0]  i_alu_psw;
	logic        i_alu_ready;
	logic        i_jp_active;
	mc51_bus_t   o_bus;
	mc51_phase_e o_phase;
	wire  [15:0] o_pc;
	wire  [7:0]  o_acc;
	wire  [7:0]  o_b;
	wire  [7:0]  o_sp;
	wire  [7:0]  o_dph;
	wire  [7:0]  o_dpl;
	wire  [7:0]  o_psw;
	wire  [7:0]  o_instr_buf;
	wire  [7:0]  o_s2_buf;
	wire         o_instr_done;

	// Reference model state
	logic [15:0] m_pc;
	logic [7:0]  m_acc;
	logic [7:0]  m_b;
	logic [7:0]  m_sp;
	logic [7:0]  m_dph;
	logic [7:0]  m_dpl;
	logic [7:0]  m_psw;
	logic [7:0]  m_instr;
	logic [7:0]  m_s2;
	logic [7:0]  m_iram [0:127];
	// External ROM and RAM image
	logic [7:0]  mem [0:2047];
	logic [16:0] lfsr;
	// Check strobes for the assertions
	logic        chk_en;
	logic        chk_s2;
	logic        chk_rst;
	logic        chk_halt;
	int          errors;
	int          tests;
	int          failed_tests;

	mc51_cu dut0 (.*);

	always #50 clk = ~clk;

	a_reset_state: assert property (@(posedge clk) chk_rst |->
		o_phase == S1_0 && o_pc == PC_RESET && o_bus == 3'b111 && !o_instr_done)
	else begin
		errors++;
		$display("MISMATCH at %0t: state after reset is wrong", $time);
	end

	// Done pulse only in the S6_1 cycle
	a_done: assert property (@(posedge clk) disable iff (!reset_n)
		o_instr_done == chk_en)
	else begin
		errors++;
		$display("MISMATCH at %0t: instruction done %b, expected %b", $time,
			$sampled(o_instr_done), chk_en);
	end

	a_pc: assert property (@(posedge clk) disable iff (!reset_n) chk_en |-> o_pc == m_pc)
	else begin
		errors++;
		$display("MISMATCH at %0t: pc %h, expected %h", $time, $sampled(o_pc), m_pc);
	end

	a_instr: assert property (@(posedge clk) disable iff (!reset_n)
		chk_en |-> o_instr_buf == m_instr)
	else begin
		errors++;
		$display("MISMATCH at %0t: opcode %h, expected %h", $time,
			$sampled(o_instr_buf), m_instr);
	end

	a_s2: assert property (@(posedge clk) disable iff (!reset_n) chk_s2 |-> o_s2_buf == m_s2)
	else begin
		errors++;
		$display("MISMATCH at %0t: operand %h, expected %h", $time, $sampled(o_s2_buf), m_s2);
	end

	a_regs: assert property (@(posedge clk) disable iff (!reset_n) chk_en |->
		{o_acc, o_b, o_sp, o_dph, o_dpl, o_psw} == {m_acc, m_b, m_sp, m_dph, m_dpl, m_psw})
	else begin
		errors++;
		$display("MISMATCH at %0t: registers %h, expected %h", $time,
			$sampled({o_acc, o_b, o_sp, o_dph, o_dpl, o_psw}),
			{m_acc, m_b, m_sp, m_dph, m_dpl, m_psw});
	end

	// Opcode fetch reads program memory
	a_fetch_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		(o_phase == S1_0 || o_phase == S1_1) |-> o_bus == 3'b010)
	else begin
		errors++;
		$display("MISMATCH at %0t: strobes %b during opcode fetch", $time, $sampled(o_bus));
	end

	// External write holds we_n alone
	a_wr_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		o_phase == S5_1 |-> o_bus == 3'b101)
	else begin
		errors++;
		$display("MISMATCH at %0t: strobes %b during external write", $time, $sampled(o_bus));
	end

	// ROM operand uses psen, RAM operand does not
	a_psen_rom: assert property (@(posedge clk) disable iff (!reset_n)
		o_phase == S2_1 && i_uop.fetch_mode == IND_EXROM |-> !o_bus.psen_n && !o_bus.rd_n)
	else begin
		errors++;
		$display("MISMATCH at %0t: strobes %b during ROM operand read", $time, $sampled(o_bus));
	end

	a_psen_ram: assert property (@(posedge clk) disable iff (!reset_n)
		o_phase == S2_1 && i_uop.fetch_mode == IND_EXRAM |-> o_bus.psen_n && !o_bus.rd_n)
	else begin
		errors++;
		$display("MISMATCH at %0t: strobes %b during RAM operand read", $time, $sampled(o_bus));
	end

	a_rdy_hold: assert property (@(posedge clk) disable iff (!reset_n)
		(o_phase == S1_1 || o_phase == S2_1 || o_phase == S5_1) && !i_data_rdy
		|=> o_phase == $past(o_phase) && o_bus == $past(o_bus))
	else begin
		errors++;
		$display("MISMATCH at %0t: wait phase left without ready", $time);
	end

	a_alu_hold: assert property (@(posedge clk) disable iff (!reset_n)
		o_phase == S4_0 && !i_alu_ready |=> o_phase == S4_0)
	else begin
		errors++;
		$display("MISMATCH at %0t: S4_0 left without ALU ready", $time);
	end

	a_halt: assert property (@(posedge clk) disable iff (!reset_n)
		chk_halt |-> o_phase == HALT && o_bus == 3'b111)
	else begin
		errors++;
		$display("MISMATCH at %0t: phase %h, bus %b, expected halt", $time,
			$sampled(o_phase), $sampled(o_bus));
	end

	// 17-bit Fibonacci LFSR, taps 17 and 14
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr[16] ^ lfsr[13];
		lfsr = {lfsr[15:0], fb};
		return fb;
	endfunction

	// Ready delay of 0 to 3 cycles
	function automatic int rand_delay();
		int d;
		d = 2 * int'(lfsr_bit());
		d = d + int'(lfsr_bit());
		return d;
	endfunction

	function automatic mc51_uop_t make_uop(input mc51_fetch_mode_e fm,
		input mc51_write_mode_e wm, input mc51_reg_tar_e tar, input mc51_reg_src_e src,
		input mc51_pc_reload_e rl, input logic upd);
		mc51_uop_t u;
		u.fetch_mode   = fm;
		u.write_mode   = wm;
		u.reg_tar      = tar;
		u.reg_src      = src;
		u.pc_reload    = rl;
		u.s2_update_pc = upd;
		return u;
	endfunction

	// Direct read above 0x7F, non-core SFRs read zero
	function automatic logic [7:0] sfr_value(input logic [7:0] a);
		case (a)
			SFR_ACC: return m_acc;
			SFR_B:   return m_b;
			SFR_SP:  return m_sp;
			SFR_DPL: return m_dpl;
			SFR_DPH: return m_dph;
			SFR_PSW: return m_psw;
			default: return 8'h00;
		endcase
	endfunction

	task automatic sfr_write(input logic [7:0] a, input logic [7:0] d);
		case (a)
			SFR_ACC: m_acc = d;
			SFR_B:   m_b   = d;
			SFR_SP:  m_sp  = d;
			SFR_DPL: m_dpl = d;
			SFR_DPH: m_dph = d;
			default: ;
		endcase
	endtask

	task automatic load_target(input mc51_reg_tar_e tar, input logic [7:0] d);
		case (tar)
			TAR_ACC: m_acc = d;
			TAR_B:   m_b   = d;
			TAR_SP:  m_sp  = d;
			TAR_DPH: m_dph = d;
			TAR_DPL: m_dpl = d;
			default: ;
		endcase
	endtask

	task automatic apply_reset();
		reset_n     = 1'b0;
		i_uop       = '0;
		i_s2_addr   = '0;
		i_s5_addr   = '0;
		i_mem_rdata = '0;
		i_mem_wdata = '0;
		i_data_rdy  = 1'b0;
		i_alu_o1    = '0;
		i_alu_o2    = '0;
		i_alu_psw   = '0;
		i_alu_ready = 1'b0;
		i_jp_active = 1'b0;
		repeat (4) @(posedge clk);
		#10;
		// Reset state seen on the last edge in reset
		chk_rst = 1'b1;
		@(posedge clk);
		#10;
		chk_rst = 1'b0;
		reset_n = 1'b1;
		m_pc    = PC_RESET;
		m_acc   = 8'h00;
		m_b     = 8'h00;
		m_sp    = SP_RESET;
		m_dph   = 8'h00;
		m_dpl   = 8'h00;
		m_psw   = PSW_RESET;
	endtask

	// One instruction, from S1_0 until S6_1 or halt
	task automatic run_instr(input mc51_uop_t uop, input logic [15:0] s2a,
		input logic [15:0] s5a, input logic [7:0] wd, input logic [7:0] o1,
		input logic [7:0] o2, input logic [7:0] psw, input logic jp);
		int          cyc;
		int          cnt;
		int          dly;
		mc51_phase_e prev;
		logic [7:0]  src;
		logic        done;
		// Expected results
		m_instr = mem[m_pc[10:0]];
		m_pc    = m_pc + 16'd1;
		case (uop.fetch_mode)
			IND_EXROM, IND_EXRAM: begin
				m_s2 = mem[s2a[10:0]];
				if (uop.s2_update_pc) begin
					m_pc = m_pc + 16'd1;
				end
			end
			IND_IRAM: m_s2 = m_iram[s2a[6:0]];
			DIR_IRAM: m_s2 = s2a[7] ? sfr_value(s2a[7:0]) : m_iram[s2a[6:0]];
			default: ;
		endcase
		case (uop.reg_src)
			SRC_S2_BUF: src = m_s2;
			SRC_ALU_O1: src = o1;
			SRC_ALU_O2: src = o2;
			default:    src = 8'h00;
		endcase
		m_psw = psw;
		load_target(uop.reg_tar, src);
		if (uop.write_mode == WR_IND_IRAM || uop.write_mode == WR_DIR_IRAM) begin
			if (!s5a[7]) begin
				m_iram[s5a[6:0]] = wd;
			end else if (uop.write_mode == WR_DIR_IRAM) begin
				sfr_write(s5a[7:0], wd);
			end
		end
		if (jp) begin
			case (uop.pc_reload)
				PC_11B: m_pc = {m_pc[15:11], m_instr[7:5], m_s2};
				PC_ROF: m_pc = m_pc + {{8{m_s2[7]}}, m_s2};
				PC_IND: m_pc = {m_dph, m_dpl} + {8'h00, m_acc};
				default: ;
			endcase
		end
		// Bus and ALU responder
		cyc  = 0;
		cnt  = 0;
		dly  = rand_delay();
		prev = S1_0;
		done = 1'b0;
		while (!done && cyc < 100) begin
			@(posedge clk);
			#10;
			cyc++;
			chk_en      = 1'b0;
			chk_s2      = 1'b0;
			i_data_rdy  = 1'b0;
			i_alu_ready = 1'b0;
			// Wrong ALU values until ready
			i_alu_o1    = ~o1;
			i_alu_o2    = ~o2;
			i_alu_psw   = ~psw;
			if (o_phase != prev) begin
				cnt  = 0;
				dly  = rand_delay();
				prev = o_phase;
			end
			case (o_phase)
				S1_1: begin
					i_uop       = uop;
					i_s2_addr   = s2a;
					i_s5_addr   = s5a;
					i_mem_wdata = wd;
					i_jp_active = jp;
					i_mem_rdata = mem[o_pc[10:0]];
					i_data_rdy  = (cnt >= dly);
				end
				S2_1: begin
					i_mem_rdata = mem[i_s2_addr[10:0]];
					i_data_rdy  = (cnt >= dly);
				end
				S5_1: i_data_rdy = (cnt >= dly);
				S4_0: begin
					if (cnt >= dly) begin
						i_alu_ready = 1'b1;
						i_alu_o1    = o1;
						i_alu_o2    = o2;
						i_alu_psw   = psw;
					end
				end
				// ALU result held through the load cycle
				S4_1: begin
					i_alu_ready = 1'b1;
					i_alu_o1    = o1;
					i_alu_o2    = o2;
					i_alu_psw   = psw;
				end
				S6_1: begin
					chk_en = 1'b1;
					chk_s2 = (uop.fetch_mode != DISCARD);
					done   = 1'b1;
				end
				HALT: done = 1'b1;
				default: ;
			endcase
			cnt++;
		end
		if (!done) begin
			$display("Timeout: instruction stuck in phase %h at %0t", o_phase, $time);
			$display("Verification failed");
			$finish;
		end else begin
			@(posedge clk);
			#10;
			chk_en = 1'b0;
			chk_s2 = 1'b0;
		end
	endtask

	task automatic report_test(input string name, input int errs_before);
		tests++;
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			failed_tests++;
			$display("test %s: FAILED with %0d errors", name, errors - errs_before);
		end
	endtask

	initial begin
		int e;
		clk          = 1'b0;
		lfsr         = 17'd94970;
		chk_en       = 1'b0;
		chk_s2       = 1'b0;
		chk_rst      = 1'b0;
		chk_halt     = 1'b0;
		errors       = 0;
		tests        = 0;
		failed_tests = 0;
		for (int a = 0; a < 2048; a++) begin
			mem[a] = a[7:0] ^ {a[10:8], a[10:8], a[10:9]} ^ 8'h3C;
		end

		e = errors;
		apply_reset();
		repeat (3) begin
			run_instr(make_uop(DISCARD, WR_DISCARD, TAR_NONE, SRC_ZERO, PC_NUL, 1'b0),
				16'h0000, 16'h0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
		end
		report_test("fetch", e);

		e = errors;
		run_instr(make_uop(IND_EXROM, WR_DISCARD, TAR_NONE, SRC_ZERO, PC_NUL, 1'b1),
			16'h0123, 16'h0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
		run_instr(make_uop(IND_EXRAM, WR_EXRAM, TAR_NONE, SRC_ZERO, PC_NUL, 1'b0),
			16'h0456, 16'h0456, 8'h99, 8'h00, 8'h00, 8'h00, 1'b0);
		report_test("external operand", e);

		e = errors;
		run_instr(make_uop(DISCARD, WR_DISCARD, TAR_ACC, SRC_ALU_O1, PC_NUL, 1'b0),
			16'h0000, 16'h0000, 8'h00, 8'h5C, 8'h00, 8'h81, 1'b0);
		report_test("register transfer", e);

		e = errors;
		run_instr(make_uop(DISCARD, WR_DIR_IRAM, TAR_NONE, SRC_ZERO, PC_NUL, 1'b0),
			16'h0000, 16'h0030, 8'hA7, 8'h00, 8'h00, 8'h00, 1'b0);
		run_instr(make_uop(DIR_IRAM, WR_DISCARD, TAR_B, SRC_S2_BUF, PC_NUL, 1'b0),
			16'h0030, 16'h0000, 8'h00, 8'h00, 8'h00, 8'h04, 1'b0);
		run_instr(make_uop(DISCARD, WR_DIR_IRAM, TAR_DPH, SRC_ALU_O2, PC_NUL, 1'b0),
			16'h0000, {8'h00, SFR_DPL}, 8'h12, 8'h00, 8'h01, 8'h00, 1'b0);
		report_test("internal ram and sfr", e);

		e = errors;
		run_instr(make_uop(DISCARD, WR_DIR_IRAM, TAR_NONE, SRC_ZERO, PC_NUL, 1'b0),
			16'h0000, 16'h0031, 8'hFC, 8'h00, 8'h00, 8'h00, 1'b0);
		run_instr(make_uop(DIR_IRAM, WR_DISCARD, TAR_NONE, SRC_ZERO, PC_ROF, 1'b0),
			16'h0031, 16'h0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b1);
		run_instr(make_uop(IND_EXROM, WR_DISCARD, TAR_NONE, SRC_ZERO, PC_11B, 1'b1),
			16'h0277, 16'h0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b1);
		run_instr(make_uop(DISCARD, WR_DISCARD, TAR_NONE, SRC_ZERO, PC_IND, 1'b0),
			16'h0000, 16'h0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b1);
		run_instr(make_uop(IND_EXROM, WR_DISCARD, TAR_NONE, SRC_ZERO, PC_11B, 1'b1),
			16'h0345, 16'h0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
		report_test("jumps", e);

		e = errors;
		run_instr(make_uop(IND_IRAM, WR_DISCARD, TAR_NONE, SRC_ZERO, PC_NUL, 1'b0),
			16'h0090, 16'h0000, 8'h00, 8'h00, 8'h00, 8'h00, 1'b0);
		chk_halt = 1'b1;
		repeat (8) @(posedge clk);
		#10;
		chk_halt = 1'b0;
		apply_reset();
		report_test("halt", e);

		$display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
hw/mc51_pkg.sv
hw/mc51_phase_seq.sv
hw/mc51_core_regs.sv
hw/mc51_pc_unit.sv
hw/mc51_data_space.sv
hw/mc51_cu.sv
test/tb_mc51_cu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the mc51_cu testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_mc51_cu -f list.f -o sim_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Verification passed"; then
	exit 0
fi
exit 1
